// File: common/exu_pkg.sv
//*********************************************************************
// Execute stage package
// Shared operand, PC, opcode, branch prediction and BTB index/tag
// types for the integer execute stage
//*********************************************************************

package exu_pkg;

   // Default global history length
   localparam int GHR_SIZE_DEF = 8;

   typedef logic [31:0] data_t;                 // Operand or result word
   typedef logic [31:1] pc_t;                   // Halfword aligned PC
   typedef logic [12:1] brimm_t;                // Branch/jump offset in halfwords
   typedef logic [7:0]  btb_index_t;            // BTB index
   typedef logic [4:0]  btb_tag_t;              // BTB tag

   // ALU operations, branches and JAL included
   // Seventeen operations need a 5-bit code
   typedef enum logic [4:0] {
      OP_ADD  = 5'd0,
      OP_SUB  = 5'd1,
      OP_AND  = 5'd2,
      OP_OR   = 5'd3,
      OP_XOR  = 5'd4,
      OP_SLT  = 5'd5,
      OP_SLTU = 5'd6,
      OP_SLL  = 5'd7,
      OP_SRL  = 5'd8,
      OP_SRA  = 5'd9,
      OP_BEQ  = 5'd10,
      OP_BNE  = 5'd11,
      OP_BLT  = 5'd12,
      OP_BGE  = 5'd13,
      OP_BLTU = 5'd14,
      OP_BGEU = 5'd15,
      OP_JAL  = 5'd16
   } alu_op_e;

   // Decoder request to the ALU
   typedef struct packed {
      logic    valid;                           // ALU instruction present
      alu_op_e op;
   } alu_pkt_t;

   // Branch prediction packet, also carries the resolved outcome
   typedef struct packed {
      logic       valid;                        // Predicted branch
      logic       ataken;                       // Taken, predicted or actual
      logic       misp;                         // Mispredicted
      logic       way;                          // BTB way
      logic [1:0] hist;                         // BHT counter
   } predict_pkt_t;

   // Operand bypass selects, one hot or zero
   typedef struct packed {
      logic x_result;                           // From X-stage ALU result
      logic r_result;                           // From R-stage result
      logic load_result;                        // From load data
   } bypass_t;

endpackage

// File: verilog/exu_operand_sel.sv
//*********************************************************************
// D-stage operand select
// Picks RS1 and RS2 from bypass data, PC, GPR or immediate
//*********************************************************************

module exu_operand_sel (
   input  exu_pkg::bypass_t   i_bypass1,        // RS1 bypass selects
   input  exu_pkg::bypass_t   i_bypass2,        // RS2 bypass selects
   input  exu_pkg::data_t     i_result_x,       // X-stage ALU result
   input  exu_pkg::data_t     i_result_r,       // R-stage result
   input  exu_pkg::data_t     i_load_result,    // Load data
   input  exu_pkg::data_t     i_gpr_rs1,
   input  exu_pkg::data_t     i_gpr_rs2,
   input  logic               i_rs1_en,         // Qualify GPR RS1
   input  logic               i_rs2_en,         // Qualify GPR RS2
   input  logic               i_select_pc,      // PC to RS1 for JAL
   input  exu_pkg::data_t     i_immed,
   input  exu_pkg::pc_t       i_pc_d,
   output exu_pkg::data_t     o_rs1,
   output exu_pkg::data_t     o_rs2
);

   exu_pkg::data_t bypass_data1;
   exu_pkg::data_t bypass_data2;

   // AND-OR mux over the bypass sources
   function automatic exu_pkg::data_t bypass_mux(input exu_pkg::bypass_t sel,
                                                 input exu_pkg::data_t   res_x,
                                                 input exu_pkg::data_t   res_r,
                                                 input exu_pkg::data_t   load);
      return ({32{sel.x_result}}    & res_x) |
             ({32{sel.r_result}}    & res_r) |
             ({32{sel.load_result}} & load);
   endfunction

   assign bypass_data1 = bypass_mux(i_bypass1, i_result_x, i_result_r, i_load_result);
   assign bypass_data2 = bypass_mux(i_bypass2, i_result_x, i_result_r, i_load_result);

   always_comb begin
      if (|i_bypass1) begin
         o_rs1 = bypass_data1;
      end else if (i_select_pc) begin
         o_rs1 = {i_pc_d, 1'b0};                // Byte address of the PC
      end else if (i_rs1_en) begin
         o_rs1 = i_gpr_rs1;
      end else begin
         o_rs1 = '0;
      end
   end

   always_comb begin
      if (|i_bypass2) begin
         o_rs2 = bypass_data2;
      end else if (i_rs2_en) begin
         o_rs2 = i_gpr_rs2;
      end else begin
         o_rs2 = i_immed;                       // Immediate forms
      end
   end

endmodule

// File: alu/exu_alu.sv
//*********************************************************************
// X-stage ALU
// Registers the D-stage request, computes the result, resolves
// branches and JAL, and selects the final flush and its target
//*********************************************************************

module exu_alu (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_x_en,             // Advance D to X
   input  exu_pkg::alu_pkt_t      i_ap,
   input  exu_pkg::data_t         i_rs1,
   input  exu_pkg::data_t         i_rs2,
   input  exu_pkg::pc_t           i_pc_d,
   input  exu_pkg::brimm_t        i_brimm,
   input  exu_pkg::predict_pkt_t  i_predict_d,
   input  logic                   i_flush_lower,      // Trap redirect
   input  exu_pkg::pc_t           i_flush_path_lower,
   output exu_pkg::data_t         o_result_x,
   output exu_pkg::pc_t           o_pc_x,
   output exu_pkg::predict_pkt_t  o_predict_x,        // Resolved packet
   output logic                   o_valid_x,
   output logic                   o_flush_upper_x,    // Branch redirect
   output logic                   o_flush_final,
   output exu_pkg::pc_t           o_flush_path_final
);

   exu_pkg::alu_pkt_t      ap_x;
   exu_pkg::data_t         a_x;
   exu_pkg::data_t         b_x;
   exu_pkg::brimm_t        brimm_x;
   exu_pkg::predict_pkt_t  pp_x;
   logic                   valid_x;
   logic                   is_cond;
   logic                   cond_met;
   logic                   is_jal;
   logic                   actual_taken;
   logic                   misp;
   exu_pkg::pc_t           flush_path_upper;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         valid_x <= 1'b0;
      end else if (i_x_en) begin
         valid_x <= i_ap.valid & ~i_flush_lower;
      end else if (i_flush_lower) begin
         valid_x <= 1'b0;                       // Kill a held instruction
      end
   end

   always_ff @(posedge clk) begin
      if (i_x_en) begin
         ap_x    <= i_ap;
         a_x     <= i_rs1;
         b_x     <= i_rs2;
         o_pc_x  <= i_pc_d;
         brimm_x <= i_brimm;
         pp_x    <= i_predict_d;
      end
   end

   always_comb begin
      case (ap_x.op)
         exu_pkg::OP_ADD:  o_result_x = a_x + b_x;
         exu_pkg::OP_SUB:  o_result_x = a_x - b_x;
         exu_pkg::OP_AND:  o_result_x = a_x & b_x;
         exu_pkg::OP_OR:   o_result_x = a_x | b_x;
         exu_pkg::OP_XOR:  o_result_x = a_x ^ b_x;
         exu_pkg::OP_SLT:  o_result_x = {31'b0, $signed(a_x) < $signed(b_x)};
         exu_pkg::OP_SLTU: o_result_x = {31'b0, a_x < b_x};
         exu_pkg::OP_SLL:  o_result_x = a_x << b_x[4:0];
         exu_pkg::OP_SRL:  o_result_x = a_x >> b_x[4:0];
         exu_pkg::OP_SRA:  o_result_x = $signed(a_x) >>> b_x[4:0];
         exu_pkg::OP_JAL:  o_result_x = {o_pc_x, 1'b0} + 32'd4;   // Link address
         default:          o_result_x = '0;     // Branches write nothing
      endcase
   end

   always_comb begin
      is_cond = 1'b1;
      case (ap_x.op)
         exu_pkg::OP_BEQ:  cond_met = (a_x == b_x);
         exu_pkg::OP_BNE:  cond_met = (a_x != b_x);
         exu_pkg::OP_BLT:  cond_met = $signed(a_x) < $signed(b_x);
         exu_pkg::OP_BGE:  cond_met = $signed(a_x) >= $signed(b_x);
         exu_pkg::OP_BLTU: cond_met = a_x < b_x;
         exu_pkg::OP_BGEU: cond_met = a_x >= b_x;
         default: begin
            is_cond  = 1'b0;
            cond_met = 1'b0;
         end
      endcase
   end

   assign is_jal       = (ap_x.op == exu_pkg::OP_JAL);
   assign actual_taken = valid_x & ((is_cond & cond_met) | is_jal);

   // A taken branch the BTB missed counts as a mispredict
   assign misp = valid_x & (is_cond | is_jal) &
                 (pp_x.valid ? (pp_x.ataken != actual_taken) : actual_taken);

   assign flush_path_upper = actual_taken ? o_pc_x + {{19{brimm_x[12]}}, brimm_x}
                                          : o_pc_x + 31'd2;

   always_comb begin
      o_predict_x        = pp_x;
      o_predict_x.valid  = valid_x & (pp_x.valid | is_cond | is_jal);
      o_predict_x.ataken = actual_taken;
      o_predict_x.misp   = misp;
   end

   assign o_valid_x          = valid_x;
   assign o_flush_upper_x    = misp;
   assign o_flush_final      = i_flush_lower | misp;
   assign o_flush_path_final = i_flush_lower ? i_flush_path_lower : flush_path_upper;

endmodule

// File: branch/exu_ghr.sv
//*********************************************************************
// Global branch history
// Speculative history at D and resolved history at X, with the
// D history restored from the resolved one on a flush
//*********************************************************************

module exu_ghr #(
   parameter int GHR_SIZE = exu_pkg::GHR_SIZE_DEF
) (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_x_en,
   input  logic                   i_r_en,
   input  exu_pkg::predict_pkt_t  i_predict_d,     // Predicted direction
   input  exu_pkg::predict_pkt_t  i_predict_x,     // Resolved direction
   input  logic                   i_valid_x,
   input  logic                   i_flush_final,
   output logic [GHR_SIZE-1:0]    o_ghr_d,
   output logic [GHR_SIZE-1:0]    o_ghr_x
);

   logic [GHR_SIZE-1:0] ghr_d_ns;
   logic [GHR_SIZE-1:0] ghr_x_ns;
   logic                shift_d;
   logic                shift_x;

   assign shift_d = i_x_en & i_predict_d.valid;              // Predicted branch enters X
   assign shift_x = i_r_en & i_valid_x & i_predict_x.valid;  // Branch leaves X

   assign ghr_x_ns = shift_x ? {o_ghr_x[GHR_SIZE-2:0], i_predict_x.ataken} : o_ghr_x;

   always_comb begin
      if (i_flush_final) begin
         ghr_d_ns = ghr_x_ns;                   // Restore after redirect
      end else if (shift_d) begin
         ghr_d_ns = {o_ghr_d[GHR_SIZE-2:0], i_predict_d.ataken};
      end else begin
         ghr_d_ns = o_ghr_d;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ghr_d <= '0;
         o_ghr_x <= '0;
      end else begin
         o_ghr_d <= ghr_d_ns;
         o_ghr_x <= ghr_x_ns;
      end
   end

endmodule

// File: branch/exu_branch_pipe.sv
//*********************************************************************
// Branch prediction pipe
// Stages BTB index/tag and the resolved packet to R, drives the
// mispredict packet, the R-stage branch report and the next PC
//*********************************************************************

module exu_branch_pipe #(
   parameter int GHR_SIZE = exu_pkg::GHR_SIZE_DEF
) (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_x_en,
   input  logic                   i_r_en,
   input  exu_pkg::btb_index_t    i_index_d,
   input  exu_pkg::btb_tag_t      i_btag_d,
   input  exu_pkg::predict_pkt_t  i_predict_x,        // Resolved X packet
   input  logic                   i_valid_x,
   input  logic                   i_flush_upper_x,
   input  logic [GHR_SIZE-1:0]    i_ghr_x,
   input  exu_pkg::pc_t           i_flush_path_final,
   input  exu_pkg::pc_t           i_pc_x,
   output exu_pkg::predict_pkt_t  o_mp_pkt,
   output exu_pkg::btb_index_t    o_mp_index,
   output exu_pkg::btb_tag_t      o_mp_btag,
   output logic [GHR_SIZE-1:0]    o_mp_fghr,
   output logic                   o_br_valid_r,
   output logic                   o_br_mp_r,
   output logic                   o_br_way_r,
   output logic [1:0]             o_br_hist_r,
   output exu_pkg::btb_index_t    o_br_index_r,
   output exu_pkg::pc_t           o_npc_r
);

   exu_pkg::btb_index_t    index_x;
   exu_pkg::btb_tag_t      btag_x;
   exu_pkg::predict_pkt_t  pp_r;
   exu_pkg::pc_t           npc_x;

   always_ff @(posedge clk) begin
      if (i_x_en) begin
         index_x <= i_index_d;
         btag_x  <= i_btag_d;
      end
   end

   // Correct prediction continues sequentially
   assign npc_x = i_flush_upper_x ? i_flush_path_final : i_pc_x + 31'd2;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_br_valid_r <= 1'b0;
      end else if (i_r_en) begin
         o_br_valid_r <= i_valid_x & i_predict_x.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (i_r_en) begin
         pp_r         <= i_predict_x;
         o_br_index_r <= index_x;
         o_npc_r      <= npc_x;
      end
   end

   assign o_br_mp_r   = o_br_valid_r & pp_r.misp;
   assign o_br_way_r  = pp_r.way;
   assign o_br_hist_r = {2{o_br_valid_r}} & pp_r.hist;

   // Mispredict update only while the branch redirect is active
   assign o_mp_pkt   = i_flush_upper_x ? i_predict_x : '0;
   assign o_mp_index = i_flush_upper_x ? index_x     : '0;
   assign o_mp_btag  = i_flush_upper_x ? btag_x      : '0;
   assign o_mp_fghr  = i_flush_upper_x ? i_ghr_x     : '0;

endmodule

// File: verilog/exu_top.sv
//*********************************************************************
// Integer execute stage top
// Connects operand select, ALU, history registers and branch pipe
//*********************************************************************

module exu_top #(
   parameter int GHR_SIZE = exu_pkg::GHR_SIZE_DEF
) (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_x_en,             // Advance D to X
   input  logic                   i_r_en,             // Advance X to R
   input  exu_pkg::alu_pkt_t      i_ap,
   input  exu_pkg::bypass_t       i_bypass1,
   input  exu_pkg::bypass_t       i_bypass2,
   input  exu_pkg::data_t         i_result_r,
   input  exu_pkg::data_t         i_load_result,
   input  exu_pkg::data_t         i_gpr_rs1,
   input  exu_pkg::data_t         i_gpr_rs2,
   input  logic                   i_rs1_en,
   input  logic                   i_rs2_en,
   input  logic                   i_select_pc,
   input  exu_pkg::data_t         i_immed,
   input  exu_pkg::pc_t           i_pc_d,
   input  exu_pkg::brimm_t        i_brimm,
   input  exu_pkg::predict_pkt_t  i_predict_d,
   input  exu_pkg::btb_index_t    i_index_d,
   input  exu_pkg::btb_tag_t      i_btag_d,
   input  logic                   i_flush_lower,
   input  exu_pkg::pc_t           i_flush_path_lower,
   output exu_pkg::data_t         o_result_x,
   output exu_pkg::pc_t           o_pc_x,
   output logic                   o_flush_final,
   output exu_pkg::pc_t           o_flush_path_final,
   output logic [GHR_SIZE-1:0]    o_ghr_d,            // Speculative history
   output exu_pkg::predict_pkt_t  o_mp_pkt,
   output exu_pkg::btb_index_t    o_mp_index,
   output exu_pkg::btb_tag_t      o_mp_btag,
   output logic [GHR_SIZE-1:0]    o_mp_fghr,
   output logic                   o_br_valid_r,
   output logic                   o_br_mp_r,
   output logic                   o_br_way_r,
   output logic [1:0]             o_br_hist_r,
   output exu_pkg::btb_index_t    o_br_index_r,
   output exu_pkg::pc_t           o_npc_r
);

   exu_pkg::data_t         rs1_d;
   exu_pkg::data_t         rs2_d;
   exu_pkg::predict_pkt_t  predict_x;
   logic                   valid_x;
   logic                   flush_upper_x;
   logic [GHR_SIZE-1:0]    ghr_x;

   exu_operand_sel u_operand_sel (
      .i_bypass1     (i_bypass1),
      .i_bypass2     (i_bypass2),
      .i_result_x    (o_result_x),
      .i_result_r    (i_result_r),
      .i_load_result (i_load_result),
      .i_gpr_rs1     (i_gpr_rs1),
      .i_gpr_rs2     (i_gpr_rs2),
      .i_rs1_en      (i_rs1_en),
      .i_rs2_en      (i_rs2_en),
      .i_select_pc   (i_select_pc),
      .i_immed       (i_immed),
      .i_pc_d        (i_pc_d),
      .o_rs1         (rs1_d),
      .o_rs2         (rs2_d)
   );

   exu_alu u_alu (
      .clk                (clk),
      .i_rst              (i_rst),
      .i_x_en             (i_x_en),
      .i_ap               (i_ap),
      .i_rs1              (rs1_d),
      .i_rs2              (rs2_d),
      .i_pc_d             (i_pc_d),
      .i_brimm            (i_brimm),
      .i_predict_d        (i_predict_d),
      .i_flush_lower      (i_flush_lower),
      .i_flush_path_lower (i_flush_path_lower),
      .o_result_x         (o_result_x),
      .o_pc_x             (o_pc_x),
      .o_predict_x        (predict_x),
      .o_valid_x          (valid_x),
      .o_flush_upper_x    (flush_upper_x),
      .o_flush_final      (o_flush_final),
      .o_flush_path_final (o_flush_path_final)
   );

   exu_ghr #(
      .GHR_SIZE (GHR_SIZE)
   ) u_ghr (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_x_en        (i_x_en),
      .i_r_en        (i_r_en),
      .i_predict_d   (i_predict_d),
      .i_predict_x   (predict_x),
      .i_valid_x     (valid_x),
      .i_flush_final (o_flush_final),
      .o_ghr_d       (o_ghr_d),
      .o_ghr_x       (ghr_x)
   );

   exu_branch_pipe #(
      .GHR_SIZE (GHR_SIZE)
   ) u_branch_pipe (
      .clk                (clk),
      .i_rst              (i_rst),
      .i_x_en             (i_x_en),
      .i_r_en             (i_r_en),
      .i_index_d          (i_index_d),
      .i_btag_d           (i_btag_d),
      .i_predict_x        (predict_x),
      .i_valid_x          (valid_x),
      .i_flush_upper_x    (flush_upper_x),
      .i_ghr_x            (ghr_x),
      .i_flush_path_final (o_flush_path_final),
      .i_pc_x             (o_pc_x),
      .o_mp_pkt           (o_mp_pkt),
      .o_mp_index         (o_mp_index),
      .o_mp_btag          (o_mp_btag),
      .o_mp_fghr          (o_mp_fghr),
      .o_br_valid_r       (o_br_valid_r),
      .o_br_mp_r          (o_br_mp_r),
      .o_br_way_r         (o_br_way_r),
      .o_br_hist_r        (o_br_hist_r),
      .o_br_index_r       (o_br_index_r),
      .o_npc_r            (o_npc_r)
   );

endmodule

// File: verif/exu_sva.sv
//**********************************************************************
// Execute stage assertions
// Flush selection and reset behavior checks bound to exu_top
//**********************************************************************

module exu_sva (
   input logic                  clk,
   input logic                  i_rst,
   input logic                  i_flush_lower,
   input exu_pkg::pc_t          i_flush_path_lower,
   input logic                  o_flush_final,
   input exu_pkg::pc_t          o_flush_path_final,
   input exu_pkg::predict_pkt_t o_mp_pkt
);

   int fail_count = 0;                          // Failed assertion count

   // No redirect right out of reset
   a_reset_flush: assert property (@(posedge clk) i_rst |=> !o_flush_final)
      else begin
         fail_count++;
         $error("flush raised in the cycle after reset");
      end

   a_mp_idle: assert property (@(posedge clk) disable iff (i_rst)
      !o_flush_final |-> o_mp_pkt == '0)
      else begin
         fail_count++;
         $error("mispredict packet set without a flush");
      end

   // Trap redirect wins over the branch path and kills the next instruction
   a_lower_path: assert property (@(posedge clk) disable iff (i_rst)
      i_flush_lower |=> o_mp_pkt == '0 &&
                        $past(o_flush_path_final) == $past(i_flush_path_lower))
      else begin
         fail_count++;
         $error("lower flush did not select its path or kill the next instruction");
      end

endmodule

bind exu_top exu_sva u_sva (
   .clk                (clk),
   .i_rst              (i_rst),
   .i_flush_lower      (i_flush_lower),
   .i_flush_path_lower (i_flush_path_lower),
   .o_flush_final      (o_flush_final),
   .o_flush_path_final (o_flush_path_final),
   .o_mp_pkt           (o_mp_pkt)
);

// File: verif/exu_tb.sv
//**********************************************************************
// Execute stage testbench
// Applies a table of ALU, bypass and branch rows to exu_top, checks
// X results, flushes, mispredict data and the R-stage report
//**********************************************************************

module exu_tb;

   localparam int GHR = exu_pkg::GHR_SIZE_DEF;

   typedef struct packed {
      exu_pkg::alu_op_e op;
      logic [31:0]      a;
      logic [31:0]      b;                      // GPR RS2 or immediate
      logic             rs2_en;
      logic             sel_pc;
      logic             byp;                    // RS1 from X result
      logic             rnd;                    // Expected values from the model
      logic [31:0]      pc;                     // Byte address
      logic [11:0]      brimm;
      logic             pv;
      logic             pt;
      logic [7:0]       idx;
      logic [4:0]       tag;
      logic             flo;                    // Lower flush while in X
      logic [31:0]      flop;
      logic [31:0]      er;
      logic             ef;
      logic [31:0]      ep;
   } row_t;

   logic clk;
   logic i_rst, i_x_en, i_r_en, i_rs1_en, i_rs2_en, i_select_pc, i_flush_lower;
   exu_pkg::alu_pkt_t     i_ap;
   exu_pkg::bypass_t      i_bypass1, i_bypass2;
   exu_pkg::data_t        i_result_r, i_load_result, i_gpr_rs1, i_gpr_rs2, i_immed;
   exu_pkg::pc_t          i_pc_d, i_flush_path_lower;
   exu_pkg::brimm_t       i_brimm;
   exu_pkg::predict_pkt_t i_predict_d;
   exu_pkg::btb_index_t   i_index_d;
   exu_pkg::btb_tag_t     i_btag_d;
   exu_pkg::data_t        o_result_x;
   exu_pkg::pc_t          o_pc_x, o_flush_path_final, o_npc_r;
   logic                  o_flush_final, o_br_valid_r, o_br_mp_r, o_br_way_r;
   logic [GHR-1:0]        o_ghr_d, o_mp_fghr;
   exu_pkg::predict_pkt_t o_mp_pkt;
   exu_pkg::btb_index_t   o_mp_index, o_br_index_r;
   exu_pkg::btb_tag_t     o_mp_btag;
   logic [1:0]            o_br_hist_r;

   row_t           rows[$];
   logic [7:0]     exp_mp[$];
   logic [GHR-1:0] exp_fghr[$];
   logic [GHR-1:0] exp_ghrd[$];
   logic           exp_brv[$];
   logic [31:0]    exp_npc[$];
   integer         seed = 32'h4e3786a8;
   int             errors = 0;
   int             cycles = 0;
   int             limit = 1000;

   exu_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (DUT.u_sva.fail_count != 0) begin
         $display("A bound assertion on exu_top failed");
         $display("Test FAILED");
         $fatal(1);
      end else if (cycles > limit) begin
         $display("Timeout after %0d cycles, rows did not complete", cycles);
         $display("Test FAILED");
         $fatal(1);
      end
   end

   function automatic logic [31:0] alu_ref(exu_pkg::alu_op_e op, logic [31:0] a,
                                           logic [31:0] b);
      case (op)
         exu_pkg::OP_ADD:  return a + b;
         exu_pkg::OP_SUB:  return a - b;
         exu_pkg::OP_AND:  return a & b;
         exu_pkg::OP_OR:   return a | b;
         exu_pkg::OP_XOR:  return a ^ b;
         exu_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exu_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
         exu_pkg::OP_SLL:  return a << b[4:0];
         exu_pkg::OP_SRL:  return a >> b[4:0];
         exu_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
         default:          return 32'd0;
      endcase
   endfunction

   function automatic logic taken_ref(exu_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b);
      case (op)
         exu_pkg::OP_BEQ:  return a == b;
         exu_pkg::OP_BNE:  return a != b;
         exu_pkg::OP_BLT:  return $signed(a) < $signed(b);
         exu_pkg::OP_BGE:  return $signed(a) >= $signed(b);
         exu_pkg::OP_BLTU: return a < b;
         exu_pkg::OP_BGEU: return a >= b;
         exu_pkg::OP_JAL:  return 1'b1;
         default:          return 1'b0;
      endcase
   endfunction

   task automatic add(exu_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b, logic rs2_en,
                      logic sel_pc, logic byp, logic [31:0] pc, logic [11:0] brimm,
                      logic pv, logic pt, logic [7:0] idx, logic [4:0] tag, logic flo,
                      logic [31:0] flop, logic [31:0] er, logic ef, logic [31:0] ep);
      rows.push_back(row_t'{op, a, b, rs2_en, sel_pc, byp, 1'b0, pc, brimm, pv, pt, idx, tag,
                            flo, flop, er, ef, ep});
   endtask

   task automatic add_random();
      row_t r;
      r = '0;
      r.op     = exu_pkg::alu_op_e'($unsigned($random(seed)) % 10);
      r.a      = $random(seed);
      r.b      = $random(seed);
      r.rs2_en = 1'b1;
      r.rnd    = 1'b1;
      r.pc     = 32'h900 + 32'(rows.size() * 4);
      rows.push_back(r);
   endtask

   // Reference model walks the rows in pipeline order
   task automatic build_expected();
      row_t           r;
      logic [GHR-1:0] ghr;
      logic [GHR-1:0] ghr_d;
      logic           prev_flo, prev_fl, v, isbr, tk, ms;
      logic [31:0]    path, fpath;
      ghr = '0;
      ghr_d = '0;
      prev_flo = 1'b0;
      prev_fl = 1'b0;
      for (int i = 0; i < rows.size(); i++) begin
         r     = rows[i];
         if (prev_fl) begin
            ghr_d = ghr;                        // Restored from resolved history
         end else if (r.pv) begin
            ghr_d = {ghr_d[GHR-2:0], r.pt};
         end
         exp_ghrd.push_back(ghr_d);
         v     = ~prev_flo;                     // Killed by the lower flush
         isbr  = (r.op >= exu_pkg::OP_BEQ);
         tk    = v & isbr & taken_ref(r.op, r.a, r.b);
         ms    = v & isbr & (r.pv ? (r.pt != tk) : tk);
         path  = tk ? r.pc + {{19{r.brimm[11]}}, r.brimm, 1'b0} : r.pc + 32'd4;
         fpath = r.flo ? r.flop : path;
         if (r.rnd) begin
            r.er = alu_ref(r.op, r.a, r.b);
            r.ef = r.flo | ms;
            r.ep = fpath;
            rows[i] = r;
         end
         exp_mp.push_back(ms ? {2'b01, tk, 1'b1, r.idx[0], r.tag[1:0]} : 8'h00);
         exp_fghr.push_back(ms ? ghr : '0);
         exp_brv.push_back(v & isbr);
         exp_npc.push_back(ms ? fpath : r.pc + 32'd4);
         if (v & isbr) ghr = {ghr[GHR-2:0], tk};
         prev_flo = r.flo;
         prev_fl = r.flo | ms;
      end
   endtask

   task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   task automatic drive_row(row_t r);
      i_ap.valid            = 1'b1;
      i_ap.op               = r.op;
      i_bypass1             = '0;
      i_bypass1.x_result    = r.byp;
      i_gpr_rs1             = r.a;
      i_rs1_en              = ~r.sel_pc;
      i_select_pc           = r.sel_pc;
      i_rs2_en              = r.rs2_en;
      i_gpr_rs2             = r.b;
      i_immed               = r.b;
      i_pc_d                = r.pc[31:1];
      i_brimm               = r.brimm;
      i_predict_d           = {r.pv, r.pt, 1'b0, r.idx[0], r.tag[1:0]};
      i_index_d             = r.idx;
      i_btag_d              = r.tag;
   endtask

   initial begin
      i_rst = 1'b1;
      i_x_en = 1'b1;
      i_r_en = 1'b1;
      i_ap = '0;
      i_bypass1 = '0;
      i_bypass2 = '0;
      i_result_r = '0;
      i_load_result = '0;
      i_gpr_rs1 = '0;
      i_gpr_rs2 = '0;
      i_rs1_en = 1'b0;
      i_rs2_en = 1'b0;
      i_select_pc = 1'b0;
      i_immed = '0;
      i_pc_d = '0;
      i_brimm = '0;
      i_predict_d = '0;
      i_index_d = '0;
      i_btag_d = '0;
      i_flush_lower = 1'b0;
      i_flush_path_lower = '0;
      //   op                 a             b             en sp by pc      brimm  pv pt idx    tag
      add(exu_pkg::OP_ADD,  32'd5,        32'd7,        1, 0, 0, 32'h000, 12'h0, 0, 0, 8'h0, 5'h0,
          0, 0, 32'd12, 0, 0);
      add(exu_pkg::OP_SUB,  32'd3,        32'd10,       0, 0, 0, 32'h004, 12'h0, 0, 0, 8'h0, 5'h0,
          0, 0, 32'hFFFF_FFF9, 0, 0);
      add(exu_pkg::OP_XOR,  32'd0,        32'h0000_FFFF, 1, 0, 1, 32'h008, 12'h0, 0, 0, 8'h0, 5'h0,
          0, 0, 32'hFFFF_0006, 0, 0);
      add(exu_pkg::OP_AND,  32'hF0F0_F0F0, 32'h0FF0_0FF0, 1, 0, 0, 32'h00C, 12'h0, 0, 0, 0, 0,
          0, 0, 32'h00F0_00F0, 0, 0);
      add(exu_pkg::OP_OR,   32'h1234_0000, 32'h0000_5678, 1, 0, 0, 32'h010, 12'h0, 0, 0, 0, 0,
          0, 0, 32'h1234_5678, 0, 0);
      add(exu_pkg::OP_SLT,  32'hFFFF_FFFF, 32'd1, 1, 0, 0, 32'h014, 12'h0, 0, 0, 0, 0,
          0, 0, 32'd1, 0, 0);
      add(exu_pkg::OP_SLTU, 32'hFFFF_FFFF, 32'd1, 1, 0, 0, 32'h018, 12'h0, 0, 0, 0, 0,
          0, 0, 32'd0, 0, 0);
      add(exu_pkg::OP_SLL,  32'd1, 32'h3F, 1, 0, 0, 32'h01C, 12'h0, 0, 0, 0, 0,
          0, 0, 32'h8000_0000, 0, 0);
      add(exu_pkg::OP_SRL,  32'h8000_0000, 32'd4, 1, 0, 0, 32'h020, 12'h0, 0, 0, 0, 0,
          0, 0, 32'h0800_0000, 0, 0);
      add(exu_pkg::OP_SRA,  32'h8000_0000, 32'd4, 1, 0, 0, 32'h024, 12'h0, 0, 0, 0, 0,
          0, 0, 32'hF800_0000, 0, 0);
      // Branches and JAL
      add(exu_pkg::OP_JAL,  32'd0, 32'd0, 1, 1, 0, 32'h200, 12'h020, 1, 1, 8'h11, 5'h02,
          0, 0, 32'h204, 0, 0);
      add(exu_pkg::OP_BEQ,  32'd5, 32'd5, 1, 0, 0, 32'h300, 12'h010, 1, 1, 8'h22, 5'h04,
          0, 0, 32'd0, 0, 0);
      add(exu_pkg::OP_BNE,  32'd5, 32'd5, 1, 0, 0, 32'h400, 12'h008, 1, 1, 8'h5A, 5'h13,
          0, 0, 32'd0, 1, 32'h404);
      add(exu_pkg::OP_BLT,  32'hFFFF_FFFE, 32'd1, 1, 0, 0, 32'h500, 12'hFF8, 0, 0, 8'hA5, 5'h0C,
          0, 0, 32'd0, 1, 32'h4F0);
      add(exu_pkg::OP_BGE,  32'd1, 32'd2, 1, 0, 0, 32'h600, 12'h010, 1, 0, 8'h33, 5'h05,
          0, 0, 32'd0, 0, 0);
      add(exu_pkg::OP_BLTU, 32'd1, 32'hFFFF_FFFF, 1, 0, 0, 32'h700, 12'h040, 1, 0, 8'h44, 5'h09,
          1, 32'h1000, 32'd0, 1, 32'h1000);
      add(exu_pkg::OP_ADD,  32'd1, 32'd1, 1, 0, 0, 32'h704, 12'h0, 0, 0, 0, 0,
          0, 0, 32'd2, 0, 0);
      add(exu_pkg::OP_BGEU, 32'd3, 32'd3, 1, 0, 0, 32'h800, 12'h004, 0, 0, 8'h67, 5'h1E,
          0, 0, 32'd0, 1, 32'h808);
      repeat (8) add_random();
      build_expected();
      limit = 16 + rows.size() + 40;
      repeat (16) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;
      for (int k = 0; k <= rows.size(); k++) begin
         @(negedge clk);
         if (k > 0) begin
            i_flush_lower      = rows[k-1].flo;
            i_flush_path_lower = rows[k-1].flop[31:1];
         end
         if (k < rows.size()) begin
            drive_row(rows[k]);
         end else begin
            i_ap = '0;
         end
         #10;
         if (k > 0) begin
            check_val("o_result_x", o_result_x, rows[k-1].er);
            check_val("o_pc_x", {o_pc_x, 1'b0}, rows[k-1].pc);
            check_val("o_flush_final", 32'(o_flush_final), 32'(rows[k-1].ef));
            if (rows[k-1].ef) begin
               check_val("o_flush_path_final", {o_flush_path_final, 1'b0}, rows[k-1].ep);
            end
            check_val("o_mp_pkt", 32'(o_mp_pkt), 32'(exp_mp[k-1]));
            check_val("o_mp_index", 32'(o_mp_index), exp_mp[k-1] != 0 ? 32'(rows[k-1].idx) : 0);
            check_val("o_mp_btag", 32'(o_mp_btag), exp_mp[k-1] != 0 ? 32'(rows[k-1].tag) : 0);
            check_val("o_mp_fghr", 32'(o_mp_fghr), 32'(exp_fghr[k-1]));
            check_val("o_ghr_d", 32'(o_ghr_d), 32'(exp_ghrd[k-1]));
         end
         if (k > 1) begin
            check_val("o_br_valid_r", 32'(o_br_valid_r), 32'(exp_brv[k-2]));
            check_val("o_br_mp_r", 32'(o_br_mp_r), 32'(exp_mp[k-2][3]));  // Misp bit
            check_val("o_npc_r", {o_npc_r, 1'b0}, exp_npc[k-2]);
            if (exp_brv[k-2]) begin
               check_val("o_br_way_r", 32'(o_br_way_r), 32'(rows[k-2].idx[0]));
               check_val("o_br_hist_r", 32'(o_br_hist_r), 32'(rows[k-2].tag[1:0]));
               check_val("o_br_index_r", 32'(o_br_index_r), 32'(rows[k-2].idx));
            end
         end
      end
      if (errors == 0 && DUT.u_sva.fail_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
common/exu_pkg.sv
verilog/exu_operand_sel.sv
alu/exu_alu.sv
branch/exu_ghr.sv
branch/exu_branch_pipe.sv
verilog/exu_top.sv
verif/exu_sva.sv
verif/exu_tb.sv
